// File: lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// row geometry, int8 elements
`define LSU_ROW_BYTES 16
`define LSU_ROW_W 128

// matrix unit result array
`define LSU_MXU_ROWS 16
`define LSU_POS_W 4

// on-chip row memories
`define LSU_NUM_BANKS 3
`define LSU_SRAM_DEPTH 256
`define LSU_SRAM_AW 8

// instruction fields
`define LSU_NUM_W 8
`define LSU_LEN_W 3

// AXI write side
`define LSU_DRAM_AW 31
`define LSU_AXI_DW 64
`define LSU_AXI_LEN_W 8
`define LSU_AXI_SIZE_W 3
`define LSU_BRESP_W 2

// size code for 8-byte beats
`define LSU_AXI_SIZE 3'd3

`endif

// File: lsu_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    // store target, decoded from the instruction
    typedef enum logic [1:0] {
        st_iram = 2'd0,
        st_wram = 2'd1,
        st_oram = 2'd2,
        st_dram = 2'd3
    } lsu_op_e;

    typedef enum logic [1:0] {
        iram = 2'd0,
        wram = 2'd1,
        oram = 2'd2
    } sram_bank_e;

    // len is a code, 2^len bytes starting at start_x
    typedef struct packed {
        lsu_op_e                 op;
        logic [`LSU_DRAM_AW-1:0] dram_addr;
        logic [`LSU_NUM_W-1:0]   num;
        logic [`LSU_LEN_W-1:0]   len;
        logic [`LSU_POS_W-1:0]   start_x;
        logic [`LSU_POS_W-1:0]   start_y;
        logic [`LSU_SRAM_AW-1:0] sram_row;
        sram_bank_e              src_bank;
    } lsu_instr_t;

    typedef logic [`LSU_MXU_ROWS-1:0][`LSU_ROW_W-1:0] mxu_rows_t;

    typedef struct packed {
        logic                      en;
        sram_bank_e                bank;
        logic [`LSU_SRAM_AW-1:0]   addr;
        logic [`LSU_ROW_BYTES-1:0] be;
        logic [`LSU_ROW_W-1:0]     data;
    } sram_wr_t;

    typedef struct packed {
        logic                    en;
        sram_bank_e              bank;
        logic [`LSU_SRAM_AW-1:0] addr;
    } sram_rd_t;

    typedef struct packed {
        logic [`LSU_DRAM_AW-1:0]    addr;
        logic [`LSU_AXI_LEN_W-1:0]  len;
        logic [`LSU_AXI_SIZE_W-1:0] size;
    } axi_aw_t;

    typedef struct packed {
        logic [`LSU_AXI_DW-1:0] data;
        logic                   last;
    } axi_w_t;

endpackage

`default_nettype wire

// File: lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             idu_vld,
    input  wire lsu_instr_t idu_instr,
    output logic            idu_rdy,
    output lsu_instr_t      instr,
    output logic            accept,
    output logic            mxu_start,
    output logic            dram_start,
    input  wire             mxu_done,
    input  wire             dram_done
);

    logic busy;
    logic is_dram;
    logic finish;

    // one instruction in flight at a time
    assign idu_rdy = ~busy;
    assign accept  = idu_vld & idu_rdy;
    assign finish  = mxu_done | dram_done;

    // decode the target once, at acceptance
    assign is_dram = (idu_instr.op == st_dram);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (finish) begin
            busy <= 1'b0;
        end
    end

    // start pulses land with the held instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mxu_start  <= 1'b0;
            dram_start <= 1'b0;
        end else begin
            mxu_start  <= accept & ~is_dram;
            dram_start <= accept & is_dram;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr <= idu_instr;
        end
    end

endmodule

`default_nettype wire

// File: lsu_mxu_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_mxu_store import lsu_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             start,
    input  wire lsu_instr_t instr,
    input  wire mxu_rows_t  mxu_rows,
    input  wire             mxu_data_rdy,
    output sram_wr_t        sram_wr,
    output logic            done
);

    logic                      active;
    logic [`LSU_NUM_W-1:0]     rows_left;
    logic [`LSU_POS_W-1:0]     row_sel;
    logic [`LSU_SRAM_AW-1:0]   wr_addr;
    logic                      wr_fire;
    logic [`LSU_POS_W:0]       win_end;
    logic [`LSU_ROW_W-1:0]     row_data;
    logic [`LSU_ROW_W-1:0]     wr_data;
    logic [`LSU_ROW_BYTES-1:0] be;
    sram_bank_e                bank;

    // one row per cycle while the matrix data is ready
    assign wr_fire  = active & mxu_data_rdy;
    assign done     = wr_fire & (rows_left == 'd1);
    assign row_data = mxu_rows[row_sel];

    // window end is exclusive, bytes past 15 simply never match
    assign win_end = {1'b0, instr.start_x} + ({{`LSU_POS_W{1'b0}}, 1'b1} << instr.len);

    always_comb begin
        for (int i = 0; i < `LSU_ROW_BYTES; i++) begin
            be[i] = (i >= instr.start_x) && (i < win_end);
            wr_data[i*8 +: 8] = be[i] ? row_data[i*8 +: 8] : 8'h00;
        end
    end

    always_comb begin
        case (instr.op)
            st_iram: bank = iram;
            st_wram: bank = wram;
            default: bank = oram;
        endcase
    end

    always_comb begin
        sram_wr.en   = wr_fire;
        sram_wr.bank = bank;
        sram_wr.addr = wr_addr;
        sram_wr.be   = be;
        sram_wr.data = wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            rows_left <= '0;
        end else if (start) begin
            active    <= 1'b1;
            rows_left <= instr.num;
        end else if (wr_fire) begin
            active    <= ~done;
            rows_left <= rows_left - 1'b1;
        end
    end

    // matrix row wraps at 16, sram row just counts up
    always_ff @(posedge clk) begin
        if (start) begin
            row_sel <= instr.start_y;
            wr_addr <= instr.sram_row;
        end else if (wr_fire) begin
            row_sel <= row_sel + 1'b1;
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: lsu_dram_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_dram_store import lsu_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire lsu_instr_t        instr,
    input  wire                    err_clr,
    output sram_rd_t               sram_rd,
    input  wire [`LSU_ROW_W-1:0]   rd_data,
    output axi_aw_t                aw,
    output logic                   awvld,
    input  wire                    awrdy,
    output axi_w_t                 w,
    output logic                   wvld,
    input  wire                    wrdy,
    input  wire                    bvld,
    input  wire [`LSU_BRESP_W-1:0] bresp,
    output logic                   brdy,
    output logic                   st_err,
    output logic                   done
);

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data,
        s_resp
    } state_e;

    state_e                     state;
    logic [`LSU_ROW_W-1:0]      hold;
    logic                       hold_vld;
    logic                       hi;
    logic                       pend;
    logic [`LSU_NUM_W-1:0]      reads_left;
    logic [`LSU_AXI_LEN_W-1:0]  beats_left;
    logic [`LSU_SRAM_AW-1:0]    rd_addr;
    logic [`LSU_AXI_LEN_W-1:0]  aw_len;
    logic                       beat_take;
    logic                       rd_issue;
    logic                       load;

    // two beats per row, num of 128 wraps to 255
    assign aw_len = {instr.num[`LSU_NUM_W-2:0], 1'b0} - 1'b1;

    assign aw.addr = instr.dram_addr;
    assign aw.len  = aw_len;
    assign aw.size = `LSU_AXI_SIZE;
    assign awvld   = (state == s_addr);

    assign wvld      = (state == s_data) & hold_vld;
    assign w.data    = hi ? hold[`LSU_ROW_W-1 -: `LSU_AXI_DW] : hold[`LSU_AXI_DW-1:0];
    assign w.last    = (beats_left == '0);
    assign beat_take = wvld & wrdy;

    assign brdy = (state == s_resp);
    assign done = brdy & bvld;

    // first read at start, the rest when a low beat leaves
    assign rd_issue     = start | (beat_take & ~hi & (reads_left != '0));
    assign sram_rd.en   = rd_issue;
    assign sram_rd.bank = instr.src_bank;
    assign sram_rd.addr = start ? instr.sram_row : rd_addr;

    // rd_data holds its row until the next read, so the
    // refill can wait for the high beat to go
    assign load = pend & (~hold_vld | (beat_take & hi));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    if (awrdy) begin
                        state <= s_data;
                    end
                end
                s_data: begin
                    if (beat_take && w.last) begin
                        state <= s_resp;
                    end
                end
                s_resp: begin
                    if (bvld) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld   <= 1'b0;
            hi         <= 1'b0;
            pend       <= 1'b0;
            reads_left <= '0;
            beats_left <= '0;
            rd_addr    <= '0;
        end else if (start) begin
            hold_vld   <= 1'b0;
            hi         <= 1'b0;
            pend       <= 1'b1;
            reads_left <= instr.num - 1'b1;
            beats_left <= aw_len;
            rd_addr    <= instr.sram_row + 1'b1;
        end else begin
            if (rd_issue) begin
                pend       <= 1'b1;
                reads_left <= reads_left - 1'b1;
                rd_addr    <= rd_addr + 1'b1;
            end else if (load) begin
                pend <= 1'b0;
            end
            if (load) begin
                hold_vld <= 1'b1;
            end else if (beat_take && hi) begin
                hold_vld <= 1'b0;
            end
            if (beat_take) begin
                hi         <= ~hi;
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold <= rd_data;
        end
    end

    // error sticks until the next instruction is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_err <= 1'b0;
        end else if (err_clr) begin
            st_err <= 1'b0;
        end else if (done && (bresp != '0)) begin
            st_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: lsu_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_sram import lsu_pkg::*; (
    input  wire                   clk,
    input  wire sram_wr_t         sram_wr,
    input  wire sram_rd_t         sram_rd,
    output logic [`LSU_ROW_W-1:0] rd_data
);

    wire [`LSU_NUM_BANKS-1:0][`LSU_ROW_W-1:0] bank_rd;
    sram_bank_e                               rd_bank;

    // iram, wram, oram in bank order
    for (genvar b = 0; b < `LSU_NUM_BANKS; b++) begin : g_bank
        logic [`LSU_ROW_W-1:0] mem [`LSU_SRAM_DEPTH];
        logic [`LSU_ROW_W-1:0] rd_q;

        // byte-masked write, untouched bytes keep old contents
        always_ff @(posedge clk) begin
            if (sram_wr.en && (sram_wr.bank == b)) begin
                for (int i = 0; i < `LSU_ROW_BYTES; i++) begin
                    if (sram_wr.be[i]) begin
                        mem[sram_wr.addr][i*8 +: 8] <= sram_wr.data[i*8 +: 8];
                    end
                end
            end
        end

        // output register holds until the next read of this bank
        always_ff @(posedge clk) begin
            if (sram_rd.en && (sram_rd.bank == b)) begin
                rd_q <= mem[sram_rd.addr];
            end
        end

        assign bank_rd[b] = rd_q;
    end

    always_ff @(posedge clk) begin
        if (sram_rd.en) begin
            rd_bank <= sram_rd.bank;
        end
    end

    assign rd_data = bank_rd[rd_bank];

endmodule

`default_nettype wire

// File: lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu import lsu_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    idu_vld,
    input  wire lsu_instr_t        idu_instr,
    output logic                   idu_rdy,
    input  wire mxu_rows_t         mxu_rows,
    input  wire                    mxu_data_rdy,
    output axi_aw_t                aw,
    output logic                   awvld,
    input  wire                    awrdy,
    output axi_w_t                 w,
    output logic                   wvld,
    input  wire                    wrdy,
    input  wire                    bvld,
    input  wire [`LSU_BRESP_W-1:0] bresp,
    output logic                   brdy,
    output logic                   st_err
);

    lsu_instr_t            instr;
    logic                  accept;
    logic                  mxu_start;
    logic                  dram_start;
    logic                  mxu_done;
    logic                  dram_done;
    sram_wr_t              sram_wr;
    sram_rd_t              sram_rd;
    logic [`LSU_ROW_W-1:0] rd_data;

    lsu_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .idu_vld    (idu_vld),
        .idu_instr  (idu_instr),
        .idu_rdy    (idu_rdy),
        .instr      (instr),
        .accept     (accept),
        .mxu_start  (mxu_start),
        .dram_start (dram_start),
        .mxu_done   (mxu_done),
        .dram_done  (dram_done)
    );

    // matrix rows into iram, wram or oram
    lsu_mxu_store i_mxu_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mxu_start),
        .instr        (instr),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .sram_wr      (sram_wr),
        .done         (mxu_done)
    );

    // sram rows out over AXI write
    lsu_dram_store i_dram_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (dram_start),
        .instr   (instr),
        .err_clr (accept),
        .sram_rd (sram_rd),
        .rd_data (rd_data),
        .aw      (aw),
        .awvld   (awvld),
        .awrdy   (awrdy),
        .w       (w),
        .wvld    (wvld),
        .wrdy    (wrdy),
        .bvld    (bvld),
        .bresp   (bresp),
        .brdy    (brdy),
        .st_err  (st_err),
        .done    (dram_done)
    );

    lsu_sram i_sram (
        .clk     (clk),
        .sram_wr (sram_wr),
        .sram_rd (sram_rd),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int NUM_TESTS = 12;
    localparam int CLK_HALF  = 20;

    typedef struct packed {
        lsu_instr_t instr;
        logic       stall;
        logic       err;
        logic [8:0] beats;
    } test_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    idu_vld;
    lsu_instr_t              idu_instr;
    logic                    idu_rdy;
    mxu_rows_t               mxu_rows;
    logic                    mxu_data_rdy = 1'b0;
    axi_aw_t                 aw;
    logic                    awvld;
    logic                    awrdy = 1'b0;
    axi_w_t                  w;
    logic                    wvld;
    logic                    wrdy = 1'b0;
    logic                    bvld = 1'b0;
    logic [`LSU_BRESP_W-1:0] bresp = '0;
    logic                    brdy;
    logic                    st_err;

    test_t                 tests [NUM_TESTS];
    logic [`LSU_ROW_W-1:0] model [3][`LSU_SRAM_DEPTH];
    axi_aw_t               aw_q [$];
    axi_w_t                w_q [$];
    logic                  stall_on = 1'b0;
    logic                  err_on = 1'b0;
    logic                  b_pend = 1'b0;
    int                    cycles = 0;
    int                    limit = 0;
    int                    errors = 0;
    int                    checks = 0;

    always #CLK_HALF clk = ~clk;

    lsu i_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .idu_vld      (idu_vld),
        .idu_instr    (idu_instr),
        .idu_rdy      (idu_rdy),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .aw           (aw),
        .awvld        (awvld),
        .awrdy        (awrdy),
        .w            (w),
        .wvld         (wvld),
        .wrdy         (wrdy),
        .bvld         (bvld),
        .bresp        (bresp),
        .brdy         (brdy),
        .st_err       (st_err)
    );

    // AXI slave and matrix ready, random gaps only when the test asks
    always @(posedge clk) begin
        if (!rst_n) begin
            awrdy        <= 1'b0;
            wrdy         <= 1'b0;
            bvld         <= 1'b0;
            b_pend       <= 1'b0;
            mxu_data_rdy <= 1'b0;
        end else begin
            mxu_data_rdy <= stall_on ? ($urandom_range(2, 0) != 0) : 1'b1;
            awrdy        <= stall_on ? ($urandom_range(3, 0) == 0) : 1'b1;
            wrdy         <= stall_on ? ($urandom_range(2, 0) != 0) : 1'b1;
            if (bvld && brdy) begin
                bvld   <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvld) begin
                bvld  <= !stall_on || ($urandom_range(1, 0) == 1);
                bresp <= err_on ? 2'b10 : 2'b00;
            end
            // response only after the last write beat
            if (wvld && wrdy && w.last) begin
                b_pend <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (awvld && awrdy) begin
            aw_q.push_back(aw);
        end
        if (wvld && wrdy) begin
            w_q.push_back(w);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped finishing instructions", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR aw got %h exp %h", got, exp);
        end
    endtask

    task automatic check_w(input int idx, input axi_w_t got, input axi_w_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR w beat %0d got %h exp %h", idx, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    function automatic lsu_instr_t make_instr(input lsu_op_e op, input int addr, input int num,
                                              input int len, input int sx, input int sy,
                                              input int row, input sram_bank_e src);
        lsu_instr_t ins;
        ins.op        = op;
        ins.dram_addr = `LSU_DRAM_AW'(addr);
        ins.num       = `LSU_NUM_W'(num);
        ins.len       = `LSU_LEN_W'(len);
        ins.start_x   = `LSU_POS_W'(sx);
        ins.start_y   = `LSU_POS_W'(sy);
        ins.sram_row  = `LSU_SRAM_AW'(row);
        ins.src_bank  = src;
        return ins;
    endfunction

    function automatic int bank_of(input lsu_op_e op);
        case (op)
            st_iram: return 0;
            st_wram: return 1;
            default: return 2;
        endcase
    endfunction

    // window is start_x for 2^len bytes, anything past byte 15 dropped
    task automatic model_store(input lsu_instr_t ins, input mxu_rows_t rows);
        int                      b;
        int                      width;
        logic [`LSU_SRAM_AW-1:0] addr;
        logic [`LSU_ROW_W-1:0]   src;
        b     = bank_of(ins.op);
        width = 1 << ins.len;
        for (int k = 0; k < ins.num; k++) begin
            src  = rows[(ins.start_y + k) % `LSU_MXU_ROWS];
            addr = `LSU_SRAM_AW'(ins.sram_row + k);
            for (int i = 0; i < `LSU_ROW_BYTES; i++) begin
                if (i >= ins.start_x && i < ins.start_x + width) begin
                    model[b][addr][i*8 +: 8] = src[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_dram(input lsu_instr_t ins, input int beats);
        axi_aw_t                 exp_aw;
        axi_w_t                  exp_w;
        logic [`LSU_SRAM_AW-1:0] addr;
        logic [`LSU_ROW_W-1:0]   row;
        exp_aw.addr = ins.dram_addr;
        exp_aw.len  = `LSU_AXI_LEN_W'(2 * ins.num - 1);
        exp_aw.size = 3'd3;
        if (aw_q.size() != 1) begin
            errors++;
            $display("saw %0d write addresses instead of one", aw_q.size());
        end else begin
            check_aw(aw_q[0], exp_aw);
        end
        if (w_q.size() != beats) begin
            errors++;
            $display("saw %0d write beats, expected %0d", w_q.size(), beats);
        end
        for (int n = 0; n < beats && n < w_q.size(); n++) begin
            addr       = `LSU_SRAM_AW'(ins.sram_row + n / 2);
            row        = model[int'(ins.src_bank)][addr];
            // low half of the row goes first
            exp_w.data = (n % 2 == 0) ? row[63:0] : row[127:64];
            exp_w.last = (n == beats - 1);
            check_w(n, w_q[n], exp_w);
        end
    endtask

    task automatic run_test(input int t);
        test_t     tc;
        mxu_rows_t rows;
        int        errs_before;
        tc          = tests[t];
        errs_before = errors;
        aw_q.delete();
        w_q.delete();
        for (int r = 0; r < `LSU_MXU_ROWS; r++) begin
            for (int j = 0; j < 4; j++) begin
                rows[r][j*32 +: 32] = $urandom();
            end
        end
        @(posedge clk);
        stall_on  <= tc.stall;
        err_on    <= tc.err;
        mxu_rows  <= rows;
        idu_vld   <= 1'b1;
        idu_instr <= tc.instr;
        // ready sampled mid-cycle, acceptance is on the next edge
        @(negedge clk);
        while (!idu_rdy) begin
            @(negedge clk);
        end
        @(posedge clk);
        idu_vld <= 1'b0;
        @(negedge clk);
        // busy right after acceptance, and any old error gone
        check_bit("idu_rdy", idu_rdy, 1'b0);
        check_bit("st_err", st_err, 1'b0);
        while (!idu_rdy) begin
            @(negedge clk);
        end
        check_bit("st_err", st_err, tc.err);
        if (tc.instr.op == st_dram) begin
            check_dram(tc.instr, tc.beats);
        end else begin
            model_store(tc.instr, rows);
            if (aw_q.size() != 0 || w_q.size() != 0) begin
                errors++;
                $display("an SRAM store put traffic on the AXI write channels");
            end
        end
        $display("test %0d op %0d rows %0d: %s", t, tc.instr.op, tc.instr.num,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    task automatic add_test(input int t, input lsu_instr_t ins, input logic stall,
                            input logic err, input int beats);
        tests[t].instr = ins;
        tests[t].stall = stall;
        tests[t].err   = err;
        tests[t].beats = 9'(beats);
    endtask

    initial begin
        void'($urandom(54));
        //           op       addr          num len sx  sy  row    src
        add_test(0,  make_instr(st_oram, 0,            4, 4, 0,  0,  'h10, oram), 0, 0, 0);
        add_test(1,  make_instr(st_dram, 'h0000_1000,  4, 0, 0,  0,  'h10, oram), 0, 0, 8);
        add_test(2,  make_instr(st_oram, 0,            2, 2, 5,  3,  'h11, oram), 1, 0, 0);
        add_test(3,  make_instr(st_dram, 'h0000_2040,  3, 0, 0,  0,  'h10, oram), 1, 0, 6);
        add_test(4,  make_instr(st_iram, 0,            4, 4, 0,  14, 'h20, iram), 1, 0, 0);
        add_test(5,  make_instr(st_dram, 'h1000_0000,  4, 0, 0,  0,  'h20, iram), 1, 1, 8);
        add_test(6,  make_instr(st_wram, 0,            5, 4, 0,  13, 'hfe, wram), 0, 0, 0);
        add_test(7,  make_instr(st_dram, 'h7fff_ff00,  5, 0, 0,  0,  'hfe, wram), 1, 0, 10);
        add_test(8,  make_instr(st_wram, 0,            3, 3, 12, 7,  'hff, wram), 1, 0, 0);
        add_test(9,  make_instr(st_dram, 'h0000_0300,  3, 0, 0,  0,  'hff, wram), 0, 1, 6);
        add_test(10, make_instr(st_oram, 0,            1, 0, 15, 9,  'h13, oram), 0, 0, 0);
        add_test(11, make_instr(st_dram, 'h0040_0000,  4, 0, 0,  0,  'h10, oram), 1, 0, 8);

        limit = 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 40 + 4 * tests[t].instr.num;
        end

        rst_n     <= 1'b0;
        idu_vld   <= 1'b0;
        idu_instr <= '0;
        mxu_rows  <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("idu_rdy", idu_rdy, 1'b1);
        check_bit("awvld", awvld, 1'b0);
        check_bit("wvld", wvld, 1'b0);
        check_bit("brdy", brdy, 1'b0);
        check_bit("st_err", st_err, 1'b0);
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu.f
+incdir+.
lsu_pkg.sv
lsu_ctrl.sv
lsu_mxu_store.sv
lsu_dram_store.sv
lsu_sram.sv
lsu.sv
lsu_tb.sv
